//--- source/tmr_pkg.sv
package tmr_pkg;

	// =========================================================================
	// copy numbering
	// =========================================================================
	localparam int NUM_COPIES = 3;

	typedef logic [1:0] copy_id_t; // 0 = no valid copy

	localparam copy_id_t COPY_NONE = 2'd0;
	localparam copy_id_t COPY_1    = 2'd1; // first copy, opens a set
	localparam copy_id_t COPY_3    = 2'd3; // last copy, closes a set

	// =========================================================================
	// control FSM and vote result
	// =========================================================================
	typedef enum logic [2:0] {
		IDLE,    // no copy held
		COLLECT, // some copies held
		COMPARE, // pass over all three buffers
		VOTE,    // one cycle, pick a copy
		REPLAY   // read the picked buffer out
	} ctrl_state_t;

	typedef logic [1:0] vote_t;

	localparam vote_t VOTE_NONE  = 2'd0;
	localparam vote_t VOTE_COPY1 = 2'd1;
	localparam vote_t VOTE_COPY2 = 2'd2;
	localparam vote_t VOTE_COPY3 = 2'd3; // never chosen by the rule, kept for the mux

endpackage

//--- source/frame_parser.sv
module frame_parser #(
	parameter int ADDR_W    = 12,
	parameter int ID_OFFSET = 2
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               rx_en,
	input  logic [7:0]         rx_data,
	input  logic               parse_hold,
	output logic               wr_en,
	output logic [ADDR_W-1:0]  wr_addr,
	output logic [7:0]         wr_data,
	output tmr_pkg::copy_id_t  wr_copy,
	output logic               frame_end,
	output tmr_pkg::copy_id_t  end_copy,
	output logic [ADDR_W-1:0]  end_len
);

	// offset only has to reach the first payload byte, then it sticks
	localparam int OFF_W = $clog2(ID_OFFSET + 2);
	localparam logic [OFF_W-1:0] ID_POS  = OFF_W'(ID_OFFSET);
	localparam logic [OFF_W-1:0] PAY_POS = OFF_W'(ID_OFFSET + 1);

	logic              rx_en_q;
	logic              rx_en_d;
	logic [7:0]        rx_data_q;
	logic [OFF_W-1:0]  offset;
	logic              accept;    // frame started while not held
	logic              frame_ok;
	logic [3:0]        id_nib;
	logic              id_valid;
	logic              pay_byte;
	tmr_pkg::copy_id_t copy;
	logic [ADDR_W-1:0] pay_cnt;

	assign frame_ok = (offset == '0) ? !parse_hold : accept;
	assign id_nib   = rx_data_q[3:0];
	assign id_valid = (id_nib != 4'd0) && (id_nib <= 4'(tmr_pkg::COPY_3));
	// stop writing once the buffer is full
	assign pay_byte = rx_en_q && (offset == PAY_POS) && (copy != tmr_pkg::COPY_NONE)
		&& (pay_cnt != '1);

	// =========================================================================
	// input stage
	// =========================================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			rx_en_q <= 1'b0;
			rx_en_d <= 1'b0;
		end else begin
			rx_en_q <= rx_en;
			rx_en_d <= rx_en_q; // for the falling edge
		end
	end

	always_ff @(posedge clk) begin
		rx_data_q <= rx_data;
	end

	// =========================================================================
	// offset count and copy number
	// =========================================================================
	always_ff @(posedge clk) begin
		if (rst || !rx_en_q) begin
			offset  <= '0;
			accept  <= 1'b0;
			copy    <= tmr_pkg::COPY_NONE;
			pay_cnt <= '0;
		end else begin
			if (offset == '0)
				accept <= !parse_hold;
			if (offset != PAY_POS)
				offset <= offset + 1'b1;
			if (offset == ID_POS) begin
				// bad id or held frame, drop the whole frame
				copy <= (frame_ok && id_valid) ? id_nib[1:0] : tmr_pkg::COPY_NONE;
			end
			if (pay_byte)
				pay_cnt <= pay_cnt + 1'b1;
		end
	end

	// write strobe and frame end pulse
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_en     <= 1'b0;
			frame_end <= 1'b0;
		end else begin
			wr_en     <= pay_byte;
			frame_end <= rx_en_d && !rx_en_q && (copy != tmr_pkg::COPY_NONE);
		end
	end

	always_ff @(posedge clk) begin
		wr_addr  <= pay_cnt;
		wr_data  <= rx_data_q;
		wr_copy  <= copy;
		end_copy <= copy;
		end_len  <= pay_cnt; // count of bytes written
	end

endmodule

//--- source/copy_buffer.sv
module copy_buffer #(
	parameter int ADDR_W = 12
) (
	input  logic              clk,
	input  logic              we,
	input  logic [ADDR_W-1:0] waddr,
	input  logic [7:0]        wdata,
	input  logic [ADDR_W-1:0] raddr,
	output logic [7:0]        rdata
);

	logic [7:0] mem [2**ADDR_W];

	// write port, fed by the parser
	always_ff @(posedge clk) begin
		if (we)
			mem[waddr] <= wdata;
	end

	// read port, one cycle latency
	always_ff @(posedge clk) begin
		rdata <= mem[raddr];
	end

endmodule

//--- source/copy_comparator.sv
module copy_comparator #(
	parameter int ADDR_W = 12
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              cmp_start,
	input  logic              cmp_run,
	input  logic [7:0]        a_data,
	input  logic [7:0]        b_data,
	input  logic [ADDR_W-1:0] a_len,
	input  logic [ADDR_W-1:0] b_len,
	input  logic              a_present,
	input  logic              b_present,
	output logic              match
);

	logic            run_d;     // run level aligned to read data
	logic [ADDR_W:0] idx;       // address of the byte pair on a_data/b_data
	logic            in_window;
	logic            byte_diff;

	// lengths are equal whenever match is still set, so a_len is enough
	assign in_window = run_d && (idx < {1'b0, a_len});
	assign byte_diff = a_data != b_data;

	always_ff @(posedge clk) begin
		if (rst) begin
			run_d <= 1'b0;
			idx   <= '0;
			match <= 1'b0;
		end else begin
			run_d <= cmp_run;
			if (cmp_start) begin
				idx   <= '0;
				match <= a_present && b_present && (a_len == b_len);
			end else begin
				if (run_d)
					idx <= idx + 1'b1;
				if (in_window && byte_diff)
					match <= 1'b0; // one bad byte is enough
			end
		end
	end

endmodule

//--- source/vote_control.sv
module vote_control #(
	parameter int ADDR_W = 12
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               frame_end,
	input  tmr_pkg::copy_id_t  end_copy,
	input  logic [ADDR_W-1:0]  end_len,
	input  logic               match_12,
	input  logic               match_23,
	input  logic               match_13,
	output logic               parse_hold,
	output logic [ADDR_W-1:0]  rd_addr,
	output logic               cmp_start,
	output logic               cmp_run,
	output logic               replay_en,
	output tmr_pkg::vote_t     sel_copy,
	output logic               vote_done,
	output logic               copy_lost,
	output logic               set_dropped,
	output logic               present_1,
	output logic               present_2,
	output logic               present_3,
	output logic [ADDR_W-1:0]  len_1,
	output logic [ADDR_W-1:0]  len_2,
	output logic [ADDR_W-1:0]  len_3
);

	tmr_pkg::ctrl_state_t          state;
	logic [tmr_pkg::NUM_COPIES:1]  present;
	logic [ADDR_W-1:0]             len [1:tmr_pkg::NUM_COPIES];
	logic [ADDR_W:0]               cnt;       // pass / replay counter
	logic [ADDR_W:0]               pass_last;
	logic [ADDR_W:0]               replay_last;
	logic [ADDR_W-1:0]             max_len;
	logic [ADDR_W-1:0]             sel_len;
	logic                          accepting;
	tmr_pkg::vote_t                vote_sel;
	logic [ADDR_W-1:0]             vote_len;

	assign accepting  = (state == tmr_pkg::IDLE) || (state == tmr_pkg::COLLECT);
	assign parse_hold = !accepting;
	assign cmp_run    = state == tmr_pkg::COMPARE;
	assign replay_en  = state == tmr_pkg::REPLAY;
	assign rd_addr    = cnt[ADDR_W-1:0];

	assign present_1 = present[1];
	assign present_2 = present[2];
	assign present_3 = present[3];
	assign len_1     = len[1];
	assign len_2     = len[2];
	assign len_3     = len[3];

	// longest copy held, +2 for the read latency
	always_comb begin
		max_len = '0;
		for (int i = 1; i <= tmr_pkg::NUM_COPIES; i++) begin
			if (present[i] && (len[i] > max_len))
				max_len = len[i];
		end
	end

	assign pass_last   = {1'b0, max_len} + 1'b1;
	assign replay_last = {1'b0, sel_len} - 1'b1;

	// =========================================================================
	// vote rule, 1-2 first, then 2-3, then 1-3
	// =========================================================================
	always_comb begin
		vote_sel = tmr_pkg::VOTE_NONE;
		vote_len = len[1];
		if (match_12) begin
			vote_sel = tmr_pkg::VOTE_COPY1;
			vote_len = len[1];
		end else if (match_23) begin
			vote_sel = tmr_pkg::VOTE_COPY2;
			vote_len = len[2];
		end else if (match_13) begin
			vote_sel = tmr_pkg::VOTE_COPY1;
			vote_len = len[1];
		end
	end

	// lengths only change while frames are accepted
	always_ff @(posedge clk) begin
		if (frame_end && accepting)
			len[end_copy] <= end_len;
		if (state == tmr_pkg::VOTE)
			sel_len <= vote_len;
	end

	// =========================================================================
	// control FSM
	// =========================================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			state       <= tmr_pkg::IDLE;
			present     <= '0;
			cnt         <= '0;
			cmp_start   <= 1'b0;
			vote_done   <= 1'b0;
			set_dropped <= 1'b0;
			sel_copy    <= tmr_pkg::VOTE_NONE;
			copy_lost   <= 1'b0;
		end else begin
			cmp_start   <= 1'b0;
			vote_done   <= 1'b0;
			set_dropped <= 1'b0;
			case (state)
				tmr_pkg::IDLE, tmr_pkg::COLLECT: begin
					if (frame_end) begin
						if ((end_copy == tmr_pkg::COPY_1) && (present != '0)) begin
							// open set abandoned, start over with this copy 1
							present                 <= '0;
							present[tmr_pkg::COPY_1] <= 1'b1;
							set_dropped             <= 1'b1;
						end else begin
							present[end_copy] <= 1'b1;
						end
						if (end_copy == tmr_pkg::COPY_3) begin
							state     <= tmr_pkg::COMPARE;
							cnt       <= '0;
							cmp_start <= 1'b1; // comparators load presence/length
						end else begin
							state <= tmr_pkg::COLLECT;
						end
					end
				end
				tmr_pkg::COMPARE: begin
					if (cnt == pass_last) begin
						state <= tmr_pkg::VOTE;
						cnt   <= '0;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				tmr_pkg::VOTE: begin
					sel_copy  <= vote_sel;
					copy_lost <= !(match_12 && match_23 && match_13);
					vote_done <= 1'b1;
					cnt       <= '0;
					if ((vote_sel != tmr_pkg::VOTE_NONE) && (vote_len != '0)) begin
						state <= tmr_pkg::REPLAY;
					end else begin
						state   <= tmr_pkg::IDLE; // nothing to send
						present <= '0;
					end
				end
				tmr_pkg::REPLAY: begin
					if (cnt == replay_last) begin
						state   <= tmr_pkg::IDLE;
						present <= '0;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: state <= tmr_pkg::IDLE;
			endcase
		end
	end

endmodule

//--- source/replay_sender.sv
module replay_sender #(
	parameter int ADDR_W = 12
) (
	input  logic           clk,
	input  logic           rst,
	input  logic           replay_en,
	input  tmr_pkg::vote_t sel_copy,
	input  logic [7:0]     rdata_1,
	input  logic [7:0]     rdata_2,
	input  logic [7:0]     rdata_3,
	output logic [7:0]     data_out,
	output logic           out_en
);

	logic            rep_d;     // replay_en matched to buffer latency
	logic [ADDR_W:0] sent;      // bytes sent in this replay
	logic [7:0]      sel_data;

	always_comb begin
		case (sel_copy)
			tmr_pkg::VOTE_COPY1: sel_data = rdata_1;
			tmr_pkg::VOTE_COPY2: sel_data = rdata_2;
			tmr_pkg::VOTE_COPY3: sel_data = rdata_3;
			default:             sel_data = 8'h00;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rep_d  <= 1'b0;
			sent   <= '0;
			out_en <= 1'b0;
		end else begin
			rep_d <= replay_en;
			// never more bytes than one buffer holds
			out_en <= rep_d && !sent[ADDR_W];
			if (!rep_d)
				sent <= '0;
			else if (!sent[ADDR_W])
				sent <= sent + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		data_out <= sel_data;
	end

endmodule

//--- source/tmr_receiver_top.sv
module tmr_receiver_top #(
	parameter int ADDR_W    = 12,
	parameter int ID_OFFSET = 2
) (
	input  logic           clk,
	input  logic           rst,
	input  logic           rx_en,
	input  logic [7:0]     rx_data,
	output logic [7:0]     data_out,
	output logic           out_en,
	output logic           vote_done,
	output logic           copy_lost,
	output tmr_pkg::vote_t sel_copy,
	output logic           set_dropped
);

	logic              wr_en;
	logic [ADDR_W-1:0] wr_addr;
	logic [7:0]        wr_data;
	tmr_pkg::copy_id_t wr_copy;
	logic              frame_end;
	tmr_pkg::copy_id_t end_copy;
	logic [ADDR_W-1:0] end_len;
	logic              parse_hold;
	logic [ADDR_W-1:0] rd_addr;
	logic              cmp_start;
	logic              cmp_run;
	logic              replay_en;
	logic [7:0]        rdata [1:tmr_pkg::NUM_COPIES];
	logic              match_12;
	logic              match_23;
	logic              match_13;
	logic              present_1;
	logic              present_2;
	logic              present_3;
	logic [ADDR_W-1:0] len_1;
	logic [ADDR_W-1:0] len_2;
	logic [ADDR_W-1:0] len_3;

	// =========================================================================
	// input side
	// =========================================================================
	frame_parser #(
		.ADDR_W    (ADDR_W),
		.ID_OFFSET (ID_OFFSET)
	) u_parser (
		.clk        (clk),
		.rst        (rst),
		.rx_en      (rx_en),
		.rx_data    (rx_data),
		.parse_hold (parse_hold),
		.wr_en      (wr_en),
		.wr_addr    (wr_addr),
		.wr_data    (wr_data),
		.wr_copy    (wr_copy),
		.frame_end  (frame_end),
		.end_copy   (end_copy),
		.end_len    (end_len)
	);

	// one buffer per copy, write enable decoded from the copy number
	for (genvar i = 1; i <= tmr_pkg::NUM_COPIES; i++) begin : g_buf
		copy_buffer #(
			.ADDR_W (ADDR_W)
		) u_buf (
			.clk   (clk),
			.we    (wr_en && (wr_copy == tmr_pkg::copy_id_t'(i))),
			.waddr (wr_addr),
			.wdata (wr_data),
			.raddr (rd_addr),
			.rdata (rdata[i])
		);
	end

	// =========================================================================
	// pairwise compare
	// =========================================================================
	copy_comparator #(.ADDR_W(ADDR_W)) u_cmp_12 (
		.clk       (clk),
		.rst       (rst),
		.cmp_start (cmp_start),
		.cmp_run   (cmp_run),
		.a_data    (rdata[1]),
		.b_data    (rdata[2]),
		.a_len     (len_1),
		.b_len     (len_2),
		.a_present (present_1),
		.b_present (present_2),
		.match     (match_12)
	);

	copy_comparator #(.ADDR_W(ADDR_W)) u_cmp_23 (
		.clk       (clk),
		.rst       (rst),
		.cmp_start (cmp_start),
		.cmp_run   (cmp_run),
		.a_data    (rdata[2]),
		.b_data    (rdata[3]),
		.a_len     (len_2),
		.b_len     (len_3),
		.a_present (present_2),
		.b_present (present_3),
		.match     (match_23)
	);

	copy_comparator #(.ADDR_W(ADDR_W)) u_cmp_13 (
		.clk       (clk),
		.rst       (rst),
		.cmp_start (cmp_start),
		.cmp_run   (cmp_run),
		.a_data    (rdata[1]),
		.b_data    (rdata[3]),
		.a_len     (len_1),
		.b_len     (len_3),
		.a_present (present_1),
		.b_present (present_3),
		.match     (match_13)
	);

	// =========================================================================
	// control and output
	// =========================================================================
	vote_control #(.ADDR_W(ADDR_W)) u_ctrl (
		.clk         (clk),
		.rst         (rst),
		.frame_end   (frame_end),
		.end_copy    (end_copy),
		.end_len     (end_len),
		.match_12    (match_12),
		.match_23    (match_23),
		.match_13    (match_13),
		.parse_hold  (parse_hold),
		.rd_addr     (rd_addr),
		.cmp_start   (cmp_start),
		.cmp_run     (cmp_run),
		.replay_en   (replay_en),
		.sel_copy    (sel_copy),
		.vote_done   (vote_done),
		.copy_lost   (copy_lost),
		.set_dropped (set_dropped),
		.present_1   (present_1),
		.present_2   (present_2),
		.present_3   (present_3),
		.len_1       (len_1),
		.len_2       (len_2),
		.len_3       (len_3)
	);

	replay_sender #(.ADDR_W(ADDR_W)) u_sender (
		.clk       (clk),
		.rst       (rst),
		.replay_en (replay_en),
		.sel_copy  (sel_copy),
		.rdata_1   (rdata[1]),
		.rdata_2   (rdata[2]),
		.rdata_3   (rdata[3]),
		.data_out  (data_out),
		.out_en    (out_en)
	);

endmodule

//--- dv/tmr_receiver_properties.sv
module tmr_receiver_properties (
	input logic           clk,
	input logic           rst,
	input logic           vote_done,
	input logic           set_dropped,
	input logic           out_en,
	input tmr_pkg::vote_t sel_copy
);

	int fail_count = 0; // failed assertions so far

	// =========================================================================
	// pulse widths
	// =========================================================================
	vote_done_pulse: assert property (@(posedge clk) disable iff (rst)
		vote_done |=> !vote_done)
		else begin
			fail_count++;
			$error("vote_done stayed high for more than one cycle");
		end

	set_dropped_pulse: assert property (@(posedge clk) disable iff (rst)
		set_dropped |=> !set_dropped)
		else begin
			fail_count++;
			$error("set_dropped stayed high for more than one cycle");
		end

	// =========================================================================
	// replay rules
	// =========================================================================
	// replay starts 2 cycles after the vote
	out_en_after_vote: assert property (@(posedge clk) disable iff (rst)
		$rose(out_en) |-> $past(vote_done, 2))
		else begin
			fail_count++;
			$error("out_en rose without a vote_done two cycles before");
		end

	sel_during_replay: assert property (@(posedge clk) disable iff (rst)
		out_en |-> (sel_copy != tmr_pkg::VOTE_NONE))
		else begin
			fail_count++;
			$error("sel_copy is zero while out_en is high");
		end

endmodule

bind tmr_receiver_top tmr_receiver_properties u_props (
	.clk         (clk),
	.rst         (rst),
	.vote_done   (vote_done),
	.set_dropped (set_dropped),
	.out_en      (out_en),
	.sel_copy    (sel_copy)
);

//--- dv/tmr_receiver_tb.sv
module tmr_receiver_tb;

	localparam int ADDR_W    = 12;
	localparam int ID_OFFSET = 2;
	localparam int SEED      = 5953;
	localparam int MAX_PAY   = 24; // longest random payload
	localparam int GAP       = 6;  // idle cycles after each frame
	localparam int N_FRAMES  = 23;
	localparam int N_SETS    = 7;
	localparam int FRAME_CYC = ID_OFFSET + 1 + MAX_PAY + GAP + 1;
	localparam int SET_CYC   = 2 * MAX_PAY + 20; // compare, vote and replay
	localparam int CYCLE_LIMIT = 2 * (N_FRAMES * FRAME_CYC + N_SETS * SET_CYC) + 20;

	typedef logic [7:0] byte_q_t [$];

	logic           clk;
	logic           rst;
	logic           rx_en;
	logic [7:0]     rx_data;
	logic [7:0]     data_out;
	logic           out_en;
	logic           vote_done;
	logic           copy_lost;
	tmr_pkg::vote_t sel_copy;
	logic           set_dropped;

	byte_q_t     rx_out;         // bytes seen while out_en is high
	int          drop_cnt = 0;
	int unsigned cycle_cnt = 0;

	tmr_receiver_top #(
		.ADDR_W    (ADDR_W),
		.ID_OFFSET (ID_OFFSET)
	) dut (
		.clk         (clk),
		.rst         (rst),
		.rx_en       (rx_en),
		.rx_data     (rx_data),
		.data_out    (data_out),
		.out_en      (out_en),
		.vote_done   (vote_done),
		.copy_lost   (copy_lost),
		.sel_copy    (sel_copy),
		.set_dropped (set_dropped)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	// =========================================================================
	// monitors and timeout
	// =========================================================================
	always @(posedge clk) begin
		if (out_en)
			rx_out.push_back(data_out);
		if (set_dropped)
			drop_cnt++;
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT)
			stop_run($sformatf("timeout, no result after %0d cycles", CYCLE_LIMIT));
		else if (dut.u_props.fail_count != 0)
			stop_run("a bound protocol assertion failed");
	end

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("TEST FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic value_error(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		stop_run($sformatf("CHECK FAILED: %s got 0x%0h expected 0x%0h", name, got, exp));
	endtask

	// =========================================================================
	// payloads and reference model
	// =========================================================================
	function automatic int random_len();
		return 4 + ($urandom % (MAX_PAY - 3));
	endfunction

	function automatic byte_q_t make_payload(input int len);
		byte_q_t q;
		for (int i = 0; i < len; i++)
			q.push_back(8'($urandom));
		return q;
	endfunction

	function automatic byte_q_t corrupt(input byte_q_t p, input int idx);
		byte_q_t q;
		q = p;
		q[idx] = q[idx] ^ 8'h5A; // any nonzero mask changes the byte
		return q;
	endfunction

	function automatic bit pairs_match(input byte_q_t a, input byte_q_t b);
		bit same;
		same = a.size() == b.size();
		for (int i = 0; same && (i < a.size()); i++)
			same = a[i] == b[i];
		return same;
	endfunction

	// =========================================================================
	// drive and check
	// =========================================================================
	task automatic apply_reset();
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		assert (out_en == 1'b0) else value_error("out_en", out_en, 0);
		assert (sel_copy == 2'd0) else value_error("sel_copy", sel_copy, 0);
		assert (copy_lost == 1'b0) else value_error("copy_lost", copy_lost, 0);
	endtask

	task automatic send_frame(input logic [1:0] copy, input byte_q_t payload);
		for (int i = 0; i < ID_OFFSET; i++) begin
			@(posedge clk);
			rx_en   <= 1'b1;
			rx_data <= 8'(8'hA0 + i); // header filler
		end
		@(posedge clk);
		rx_data <= {4'h5, 2'b00, copy}; // upper nibble is ignored
		foreach (payload[i]) begin
			@(posedge clk);
			rx_data <= payload[i];
		end
		@(posedge clk);
		rx_en   <= 1'b0;
		rx_data <= 8'h00;
		repeat (GAP) @(posedge clk);
	endtask

	task automatic check_vote(input byte_q_t p1, input byte_q_t p2, input byte_q_t p3);
		bit         m12;
		bit         m23;
		bit         m13;
		logic [1:0] exp_sel;
		logic       exp_lost;
		byte_q_t    exp_data;
		int         n;
		m12 = pairs_match(p1, p2);
		m23 = pairs_match(p2, p3);
		m13 = pairs_match(p1, p3);
		exp_lost = !(m12 && m23 && m13);
		exp_sel  = 2'd0;
		if (m12) begin
			exp_sel  = 2'd1;
			exp_data = p1;
		end else if (m23) begin
			exp_sel  = 2'd2;
			exp_data = p2;
		end else if (m13) begin
			exp_sel  = 2'd1;
			exp_data = p1;
		end
		do @(posedge clk); while (!vote_done);
		rx_out.delete();
		assert (sel_copy == exp_sel) else value_error("sel_copy", sel_copy, exp_sel);
		assert (copy_lost == exp_lost) else value_error("copy_lost", copy_lost, exp_lost);
		if (exp_sel != 2'd0) begin
			n = 0;
			do begin
				@(posedge clk);
				n++;
			end while (!out_en);
			assert (n == 2) else value_error("out_en delay", n, 2);
			while (out_en) @(posedge clk);
			assert (rx_out.size() == exp_data.size())
				else value_error("out_en length", rx_out.size(), exp_data.size());
			foreach (exp_data[i]) begin
				assert (rx_out[i] == exp_data[i])
					else value_error($sformatf("data_out[%0d]", i), rx_out[i], exp_data[i]);
			end
		end else begin
			repeat (8) @(posedge clk); // no replay may start
			assert (rx_out.size() == 0) else value_error("out_en bytes", rx_out.size(), 0);
		end
	endtask

	// =========================================================================
	// directed tests
	// =========================================================================
	task automatic identical_copies();
		byte_q_t p;
		p = make_payload(random_len());
		send_frame(2'd1, p);
		send_frame(2'd2, p);
		send_frame(2'd3, p);
		check_vote(p, p, p);
	endtask

	task automatic copy1_corrupted();
		byte_q_t p;
		byte_q_t bad;
		p   = make_payload(random_len());
		bad = corrupt(p, $urandom % p.size());
		send_frame(2'd1, bad);
		send_frame(2'd2, p);
		send_frame(2'd3, p);
		check_vote(bad, p, p);
	endtask

	task automatic copy3_then_copy2_corrupted();
		byte_q_t p;
		byte_q_t bad;
		p   = make_payload(random_len());
		bad = corrupt(p, $urandom % p.size());
		send_frame(2'd1, p);
		send_frame(2'd2, p);
		send_frame(2'd3, bad);
		check_vote(p, p, bad);
		p   = make_payload(random_len()); // second set
		bad = corrupt(p, $urandom % p.size());
		send_frame(2'd1, p);
		send_frame(2'd2, bad);
		send_frame(2'd3, p);
		check_vote(p, bad, p);
	endtask

	task automatic all_copies_differ();
		byte_q_t p1;
		byte_q_t p2;
		byte_q_t p3;
		p1 = make_payload(random_len());
		p2 = corrupt(p1, 0);
		p3 = corrupt(p1, 1);
		send_frame(2'd1, p1);
		send_frame(2'd2, p2);
		send_frame(2'd3, p3);
		check_vote(p1, p2, p3);
	endtask

	task automatic short_copy2();
		byte_q_t p;
		byte_q_t short_p;
		p       = make_payload(random_len());
		short_p = p;
		void'(short_p.pop_back());
		send_frame(2'd1, p);
		send_frame(2'd2, short_p);
		send_frame(2'd3, p);
		check_vote(p, short_p, p);
	endtask

	task automatic dropped_set();
		byte_q_t old1;
		byte_q_t old2;
		byte_q_t p;
		int      drops_before;
		drops_before = drop_cnt;
		old1 = make_payload(random_len());
		old2 = make_payload(random_len());
		p    = make_payload(random_len());
		send_frame(2'd1, old1);
		send_frame(2'd2, old2);
		send_frame(2'd1, p); // abandons the open set
		assert (drop_cnt == drops_before + 1)
			else value_error("set_dropped count", drop_cnt - drops_before, 1);
		send_frame(2'd2, p);
		send_frame(2'd3, p);
		check_vote(p, p, p);
		assert (drop_cnt == drops_before + 1)
			else value_error("set_dropped count", drop_cnt - drops_before, 1);
	endtask

	initial begin
		rst     = 1'b1;
		rx_en   = 1'b0;
		rx_data = 8'h00;
		void'($urandom(SEED));
		apply_reset();
		identical_copies();
		copy1_corrupted();
		copy3_then_copy2_corrupted();
		all_copies_differ();
		short_copy2();
		dropped_set();
		repeat (4) @(posedge clk);
		if (dut.u_props.fail_count != 0) begin
			stop_run("a bound protocol assertion failed during the run");
		end else begin
			$display("TEST PASS");
			$finish;
		end
	end

endmodule

//--- files.f
source/tmr_pkg.sv
source/frame_parser.sv
source/copy_buffer.sv
source/copy_comparator.sv
source/vote_control.sv
source/replay_sender.sv
source/tmr_receiver_top.sv
dv/tmr_receiver_properties.sv
dv/tmr_receiver_tb.sv
